//--- verilog/axi_mem_config.svh
`ifndef AXI_MEM_CONFIG_SVH
`define AXI_MEM_CONFIG_SVH

// Bus geometry.
`define AXI_ID_W        4
`define AXI_ADDR_W      16
`define AXI_DATA_W      32
`define AXI_STRB_W      (`AXI_DATA_W / 8)
`define AXI_LEN_W       8
`define AXI_SIZE_W      3
`define AXI_BURST_W     2
`define AXI_RESP_W      2

// Depth in data words. It must be a power of two.
`define MEM_WORDS       1024

`define CMD_FIFO_DEPTH  4
`define RD_FIFO_DEPTH   4

`endif

//--- verilog/axi_mem_pkg.sv
`include "axi_mem_config.svh"

package axi_mem_pkg;

    typedef enum logic [`AXI_BURST_W-1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [`AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [`AXI_SIZE_W-1:0] size;
        burst_e                 burst;
    } axi_cmd_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
        logic                   last;
    } r_beat_t;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                     aclk,
    input  logic                     rstn,
    input  logic                     push,
    input  payload_t                 push_data,
    input  logic                     pop,
    output payload_t                 head,
    output logic                     empty,
    output logic                     full,
    output logic [$clog2(DEPTH):0]   count
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         store [DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic             do_push;
    logic             do_pop;

    // The extra pointer bit tells a full buffer from an empty one.
    assign count   = wr_ptr - rd_ptr;
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = store[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            store[wr_ptr[PTR_W-1:0]] <= push_data;
        end
    end

endmodule

//--- verilog/burst_addr_gen.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module burst_addr_gen import axi_mem_pkg::*; (
    input  logic                   aclk,
    input  logic                   rstn,
    input  logic                   load,
    input  axi_cmd_t               cmd,
    input  logic                   step,
    output logic [`AXI_ADDR_W-1:0] addr,
    output logic                   beat_last,
    output logic                   illegal
);

    localparam int BUS_SIZE = $clog2(`AXI_STRB_W);

    logic [`AXI_ADDR_W-1:0] cur_addr;
    logic [`AXI_ADDR_W-1:0] next_addr;
    logic [`AXI_ADDR_W-1:0] step_bytes;
    logic [`AXI_ADDR_W-1:0] wrap_mask;
    logic [`AXI_LEN_W-1:0]  len;
    logic [`AXI_LEN_W-1:0]  beat_cnt;
    logic [`AXI_SIZE_W-1:0] size;
    burst_e                 burst;

    always_comb begin
        step_bytes = `AXI_ADDR_W'(1) << size;
        wrap_mask  = ((`AXI_ADDR_W'(len) + 1'b1) << size) - 1'b1; // Window of len+1 beats.
        case (burst)
            INCR:    next_addr = cur_addr + step_bytes;
            WRAP:    next_addr = (cur_addr & ~wrap_mask) | ((cur_addr + step_bytes) & wrap_mask);
            default: next_addr = cur_addr;
        endcase
    end

    assign addr      = cur_addr;
    assign beat_last = (beat_cnt == len);
    assign illegal   = (size > `AXI_SIZE_W'(BUS_SIZE)) ||
                       ((burst == WRAP) && !(len inside {8'd1, 8'd3, 8'd7, 8'd15}));

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            cur_addr <= '0;
            len      <= '0;
            size     <= '0;
            burst    <= FIXED;
            beat_cnt <= '0;
        end else if (load) begin
            cur_addr <= cmd.addr;
            len      <= cmd.len;
            size     <= cmd.size;
            burst    <= cmd.burst;
            beat_cnt <= '0;
        end else if (step) begin
            cur_addr <= next_addr;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/axi_write_engine.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module axi_write_engine import axi_mem_pkg::*; (
    input  logic                   aclk,
    input  logic                   rstn,
    input  axi_cmd_t               aw_head,
    input  logic                   aw_empty,
    output logic                   aw_pop,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wlast,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [`AXI_ID_W-1:0]   bid,
    output logic [`AXI_RESP_W-1:0] bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`AXI_ADDR_W-1:0] mem_addr,
    output logic [`AXI_DATA_W-1:0] mem_wdata,
    output logic [`AXI_STRB_W-1:0] mem_wstrb,
    input  logic                   mem_gnt
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LOAD,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e              state;
    logic [`AXI_ADDR_W-1:0] beat_addr;
    logic                   beat_last;
    logic                   illegal;
    logic                   len_err;
    logic                   w_beat;

    burst_addr_gen addr_gen_i (
        .aclk      (aclk),
        .rstn      (rstn),
        .load      (state == WR_LOAD),
        .cmd       (aw_head),
        .step      (w_beat),
        .addr      (beat_addr),
        .beat_last (beat_last),
        .illegal   (illegal)
    );

    assign mem_req   = (state == WR_DATA) && wvalid; // Only ask for the port with data in hand.
    assign mem_we    = (state == WR_DATA);
    assign mem_addr  = beat_addr;
    assign mem_wdata = wdata;
    assign mem_wstrb = illegal ? '0 : wstrb;         // An illegal burst is drained unwritten.
    assign wready    = (state == WR_DATA) && mem_gnt;
    assign w_beat    = wvalid && wready;

    assign bvalid = (state == WR_RESP);
    assign bid    = aw_head.id;
    assign bresp  = (illegal || len_err) ? SLVERR : OKAY;
    assign aw_pop = bvalid && bready;

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            state   <= WR_IDLE;
            len_err <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: if (!aw_empty) state <= WR_LOAD;
                WR_LOAD: state <= WR_DATA;
                WR_DATA: if (w_beat && wlast) state <= WR_RESP;
                WR_RESP: if (bready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
            if (state == WR_LOAD) begin
                len_err <= 1'b0;
            end else if (w_beat && (wlast != beat_last)) begin
                len_err <= 1'b1; // WLAST disagrees with AWLEN.
            end
        end
    end

endmodule

//--- verilog/axi_read_engine.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module axi_read_engine import axi_mem_pkg::*; (
    input  logic                             aclk,
    input  logic                             rstn,
    input  axi_cmd_t                         ar_head,
    input  logic                             ar_empty,
    output logic                             ar_pop,
    output logic                             mem_req,
    output logic [`AXI_ADDR_W-1:0]           mem_addr,
    input  logic                             mem_gnt,
    input  logic [`AXI_DATA_W-1:0]           mem_rdata,
    input  logic                             mem_rvalid,
    output logic                             rq_push,
    output r_beat_t                          rq_data,
    input  logic [$clog2(`RD_FIFO_DEPTH):0]  rq_count
);

    localparam int CNT_W = $clog2(`RD_FIFO_DEPTH) + 1;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOAD,
        RD_ISSUE
    } rd_state_e;

    rd_state_e              state;
    logic [`AXI_ADDR_W-1:0] beat_addr;
    logic                   beat_last;
    logic                   illegal;
    logic [CNT_W-1:0]       occupancy;
    logic                   credit_ok;
    logic                   issue;
    logic                   p_valid;
    logic [`AXI_ID_W-1:0]   p_id;
    logic                   p_last;
    logic                   p_err;

    burst_addr_gen addr_gen_i (
        .aclk      (aclk),
        .rstn      (rstn),
        .load      (state == RD_LOAD),
        .cmd       (ar_head),
        .step      (issue),
        .addr      (beat_addr),
        .beat_last (beat_last),
        .illegal   (illegal)
    );

    // A beat in flight already owns a slot in the R queue.
    assign occupancy = rq_count + CNT_W'(p_valid);
    assign credit_ok = occupancy < CNT_W'(`RD_FIFO_DEPTH);
    assign mem_req   = (state == RD_ISSUE) && credit_ok && !illegal;
    assign mem_addr  = beat_addr;
    assign issue     = (state == RD_ISSUE) && credit_ok && (illegal || mem_gnt);
    assign ar_pop    = issue && beat_last;

    assign rq_push = p_valid && (p_err || mem_rvalid);

    always_comb begin
        rq_data.id   = p_id;
        rq_data.data = p_err ? '0 : mem_rdata;
        rq_data.resp = p_err ? SLVERR : OKAY;
        rq_data.last = p_last;
    end

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            state   <= RD_IDLE;
            p_valid <= 1'b0;
        end else begin
            p_valid <= issue;
            case (state)
                RD_IDLE:  if (!ar_empty) state <= RD_LOAD;
                RD_LOAD:  state <= RD_ISSUE;
                RD_ISSUE: if (ar_pop) state <= RD_IDLE;
                default:  state <= RD_IDLE;
            endcase
        end
    end

    // Tag of the beat whose data arrives next cycle.
    always_ff @(posedge aclk) begin
        if (issue) begin
            p_id   <= ar_head.id;
            p_last <= beat_last;
            p_err  <= illegal;
        end
    end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module mem_arbiter (
    input  logic                   aclk,
    input  logic                   rstn,
    input  logic                   w_req,
    input  logic [`AXI_ADDR_W-1:0] w_addr,
    input  logic [`AXI_DATA_W-1:0] w_wdata,
    input  logic [`AXI_STRB_W-1:0] w_wstrb,
    output logic                   w_gnt,
    input  logic                   r_req,
    input  logic [`AXI_ADDR_W-1:0] r_addr,
    output logic                   r_gnt,
    output logic [`AXI_DATA_W-1:0] r_rdata,
    output logic                   r_rvalid
);

    localparam int WORD_LSB = $clog2(`AXI_STRB_W);
    localparam int IDX_W    = $clog2(`MEM_WORDS);

    logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];
    logic [IDX_W-1:0]       w_idx;
    logic [IDX_W-1:0]       r_idx;
    logic                   last_rd;

    // Dropping the upper address bits wraps the byte address modulo the depth.
    assign w_idx = w_addr[WORD_LSB +: IDX_W];
    assign r_idx = r_addr[WORD_LSB +: IDX_W];

    // On a tie the engine that lost last time wins.
    assign w_gnt = w_req && (!r_req || last_rd);
    assign r_gnt = r_req && !w_gnt;

    always_ff @(posedge aclk or negedge rstn) begin
        if (!rstn) begin
            last_rd  <= 1'b1;
            r_rvalid <= 1'b0;
        end else begin
            r_rvalid <= r_gnt;
            if (w_gnt) begin
                last_rd <= 1'b0;
            end else if (r_gnt) begin
                last_rd <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (w_gnt) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (w_wstrb[i]) begin
                    mem[w_idx][8*i +: 8] <= w_wdata[8*i +: 8];
                end
            end
        end
        if (r_gnt) begin
            r_rdata <= mem[r_idx];
        end
    end

endmodule

//--- verilog/axi_mem_slave.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module axi_mem_slave import axi_mem_pkg::*; (
    input  logic                    aclk,
    input  logic                    rstn,
    input  logic [`AXI_ID_W-1:0]    awid,
    input  logic [`AXI_ADDR_W-1:0]  awaddr,
    input  logic [`AXI_LEN_W-1:0]   awlen,
    input  logic [`AXI_SIZE_W-1:0]  awsize,
    input  logic [`AXI_BURST_W-1:0] awburst,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXI_DATA_W-1:0]  wdata,
    input  logic [`AXI_STRB_W-1:0]  wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [`AXI_ID_W-1:0]    bid,
    output logic [`AXI_RESP_W-1:0]  bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXI_ID_W-1:0]    arid,
    input  logic [`AXI_ADDR_W-1:0]  araddr,
    input  logic [`AXI_LEN_W-1:0]   arlen,
    input  logic [`AXI_SIZE_W-1:0]  arsize,
    input  logic [`AXI_BURST_W-1:0] arburst,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXI_ID_W-1:0]    rid,
    output logic [`AXI_DATA_W-1:0]  rdata,
    output logic [`AXI_RESP_W-1:0]  rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  logic                    rready
);

    axi_cmd_t                        aw_cmd, aw_head, ar_cmd, ar_head;
    logic                            aw_empty, aw_full, aw_pop;
    logic                            ar_empty, ar_full, ar_pop;
    r_beat_t                         rq_data, r_head;
    logic                            rq_push, r_empty;
    logic [$clog2(`RD_FIFO_DEPTH):0] rq_count;
    logic                            w_mem_req, w_mem_we, w_mem_gnt;
    logic [`AXI_ADDR_W-1:0]          w_mem_addr, r_mem_addr;
    logic [`AXI_DATA_W-1:0]          w_mem_wdata, r_mem_rdata;
    logic [`AXI_STRB_W-1:0]          w_mem_wstrb;
    logic                            r_mem_req, r_mem_gnt, r_mem_rvalid;

    assign aw_cmd  = '{id: awid, addr: awaddr, len: awlen, size: awsize, burst: burst_e'(awburst)};
    assign ar_cmd  = '{id: arid, addr: araddr, len: arlen, size: arsize, burst: burst_e'(arburst)};
    assign awready = !aw_full;
    assign arready = !ar_full;

    // The R channel is the head of the read beat queue.
    assign rvalid = !r_empty;
    assign rid    = r_head.id;
    assign rdata  = r_head.data;
    assign rresp  = r_head.resp;
    assign rlast  = r_head.last;

    sync_fifo #(.payload_t(axi_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) aw_fifo_i (
        .aclk (aclk), .rstn (rstn), .push (awvalid), .push_data (aw_cmd), .pop (aw_pop),
        .head (aw_head), .empty (aw_empty), .full (aw_full), .count ()
    );

    sync_fifo #(.payload_t(axi_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) ar_fifo_i (
        .aclk (aclk), .rstn (rstn), .push (arvalid), .push_data (ar_cmd), .pop (ar_pop),
        .head (ar_head), .empty (ar_empty), .full (ar_full), .count ()
    );

    sync_fifo #(.payload_t(r_beat_t), .DEPTH(`RD_FIFO_DEPTH)) r_fifo_i (
        .aclk (aclk), .rstn (rstn), .push (rq_push), .push_data (rq_data),
        .pop (rvalid && rready), .head (r_head), .empty (r_empty), .full (), .count (rq_count)
    );

    axi_write_engine write_engine_i (
        .aclk (aclk), .rstn (rstn), .aw_head (aw_head), .aw_empty (aw_empty), .aw_pop (aw_pop),
        .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
        .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .mem_req (w_mem_req), .mem_we (w_mem_we), .mem_addr (w_mem_addr),
        .mem_wdata (w_mem_wdata), .mem_wstrb (w_mem_wstrb), .mem_gnt (w_mem_gnt)
    );

    axi_read_engine read_engine_i (
        .aclk (aclk), .rstn (rstn), .ar_head (ar_head), .ar_empty (ar_empty), .ar_pop (ar_pop),
        .mem_req (r_mem_req), .mem_addr (r_mem_addr), .mem_gnt (r_mem_gnt),
        .mem_rdata (r_mem_rdata), .mem_rvalid (r_mem_rvalid),
        .rq_push (rq_push), .rq_data (rq_data), .rq_count (rq_count)
    );

    mem_arbiter mem_arbiter_i (
        .aclk (aclk), .rstn (rstn),
        .w_req (w_mem_req && w_mem_we), .w_addr (w_mem_addr), .w_wdata (w_mem_wdata),
        .w_wstrb (w_mem_wstrb), .w_gnt (w_mem_gnt),
        .r_req (r_mem_req), .r_addr (r_mem_addr), .r_gnt (r_mem_gnt),
        .r_rdata (r_mem_rdata), .r_rvalid (r_mem_rvalid)
    );

endmodule

//--- verif/axi_mem_slave_tb.sv
`timescale 1ns/10ps
`include "axi_mem_config.svh"

module axi_mem_slave_tb import axi_mem_pkg::*; ();

    localparam int TEST_CYCLES = 200;             // Rough sum of all test lengths in cycles.
    localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

    logic                    aclk = 1'b0;
    logic                    rstn;
    logic [`AXI_ID_W-1:0]    awid, bid, arid, rid;
    logic [`AXI_ADDR_W-1:0]  awaddr, araddr;
    logic [`AXI_LEN_W-1:0]   awlen, arlen;
    logic [`AXI_SIZE_W-1:0]  awsize, arsize;
    logic [`AXI_BURST_W-1:0] awburst, arburst;
    logic [`AXI_DATA_W-1:0]  wdata, rdata;
    logic [`AXI_STRB_W-1:0]  wstrb;
    logic [`AXI_RESP_W-1:0]  bresp, rresp;
    logic                    awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                    arvalid, arready, rlast, rvalid, rready;

    logic [`AXI_DATA_W-1:0]  ref_mem [`MEM_WORDS];
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      failed_tests = 0;
    int                      cycles = 0;
    int                      mark;

    axi_mem_slave dut_i (.*);

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Word index of one beat of a full-width burst.
    function automatic int beat_word(input int start, input int len, input burst_e burst,
                                     input int beat);
        int window;
        int base;
        int addr;
        window = (len + 1) * `AXI_STRB_W;
        base   = start - (start % window);
        case (burst)
            INCR:    addr = start + beat * `AXI_STRB_W;
            WRAP:    addr = base + (start - base + beat * `AXI_STRB_W) % window;
            default: addr = start;
        endcase
        return (addr / `AXI_STRB_W) % `MEM_WORDS;
    endfunction

    task automatic write_burst(input int id, input int addr, input int len, input burst_e burst,
                               input logic [`AXI_STRB_W-1:0] strb, input resp_e exp_resp);
        logic [`AXI_DATA_W-1:0] data;
        int idx;
        int beat;
        bit done;
        @(negedge aclk);
        awid    = `AXI_ID_W'(id);
        awaddr  = `AXI_ADDR_W'(addr);
        awlen   = `AXI_LEN_W'(len);
        awsize  = 3'd2;
        awburst = burst;
        awvalid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #20;
            done = awready;
            @(negedge aclk);
        end
        awvalid = 1'b0;
        beat    = 0;
        data    = $urandom;
        while (beat <= len) begin
            wdata  = data;
            wstrb  = strb;
            wlast  = (beat == len);
            wvalid = 1'b1;
            #20;
            if (wready) begin
                if (exp_resp == OKAY) begin
                    idx = beat_word(addr, len, burst, beat);
                    for (int b = 0; b < `AXI_STRB_W; b++) begin
                        if (strb[b]) begin
                            ref_mem[idx][8*b +: 8] = data[8*b +: 8];
                        end
                    end
                end
                beat++;
                data = $urandom;
            end
            @(negedge aclk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = 1'b1;
        done   = 1'b0;
        while (!done) begin
            #20;
            if (bvalid) begin
                check("bid", 32'(bid), 32'(id));
                check("bresp", 32'(bresp), 32'(exp_resp));
                done = 1'b1;
            end
            @(negedge aclk);
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input int id, input int addr, input int len, input burst_e burst,
                              input resp_e exp_resp, input bit stall);
        logic [`AXI_DATA_W-1:0] exp_data;
        int beat;
        bit done;
        @(negedge aclk);
        arid    = `AXI_ID_W'(id);
        araddr  = `AXI_ADDR_W'(addr);
        arlen   = `AXI_LEN_W'(len);
        arsize  = 3'd2;
        arburst = burst;
        arvalid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #20;
            done = arready;
            @(negedge aclk);
        end
        arvalid = 1'b0;
        beat    = 0;
        while (beat <= len) begin
            rready = !stall || ($urandom % 3 != 0); // About one cycle in three held off.
            #20;
            if (rvalid && rready) begin
                exp_data = (exp_resp == OKAY) ? ref_mem[beat_word(addr, len, burst, beat)] : '0;
                check("rdata", rdata, exp_data);
                check("rresp", 32'(rresp), 32'(exp_resp));
                check("rid", 32'(rid), 32'(id));
                check("rlast", 32'(rlast), 32'(beat == len));
                beat++;
            end
            @(negedge aclk);
        end
        rready = 1'b0;
        #20;
        check("rvalid", 32'(rvalid), 32'(0)); // A repeated beat would still be queued.
    endtask

    task automatic test_reset_state();
        @(negedge aclk);
        #20;
        check("awready", 32'(awready), 32'(1));
        check("arready", 32'(arready), 32'(1));
        check("wready", 32'(wready), 32'(0));
        check("bvalid", 32'(bvalid), 32'(0));
        check("rvalid", 32'(rvalid), 32'(0));
    endtask

    task automatic test_single_beat();
        write_burst(1, 'h100, 0, INCR, 4'hf, OKAY);
        write_burst(2, 'h100, 0, INCR, 4'b0101, OKAY);
        read_burst(3, 'h100, 0, INCR, OKAY, 1'b0);
    endtask

    task automatic test_incr_fixed();
        write_burst(4, 'h200, 7, INCR, 4'hf, OKAY);
        read_burst(5, 'h200, 7, INCR, OKAY, 1'b0);
        write_burst(6, 'h300, 3, FIXED, 4'hf, OKAY);
        read_burst(7, 'h300, 3, FIXED, OKAY, 1'b0);
    endtask

    task automatic test_wrap();
        write_burst(8, 'h408, 3, WRAP, 4'hf, OKAY);
        read_burst(9, 'h408, 3, WRAP, OKAY, 1'b0);
        read_burst(10, 'h400, 3, INCR, OKAY, 1'b0); // Linear view of the 16 byte window.
    endtask

    task automatic test_illegal_wrap();
        write_burst(11, 'h200, 2, WRAP, 4'hf, SLVERR);
        read_burst(12, 'h200, 7, INCR, OKAY, 1'b0);
        read_burst(13, 'h200, 2, WRAP, SLVERR, 1'b0);
    endtask

    task automatic test_concurrent();
        fork
            read_burst(14, 'h200, 7, INCR, OKAY, 1'b1);
            write_burst(15, 'h600, 7, INCR, 4'hf, OKAY);
        join
        read_burst(0, 'h600, 7, INCR, OKAY, 1'b0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            failed_tests++;
            $display("Test %s: failed with %0d mismatches", name, errors - errors_before);
        end
    endtask

    initial begin
        void'($urandom(32'hb2b9));
        rstn    = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(negedge aclk);
        rstn = 1'b1;

        mark = errors;
        test_reset_state();
        report_test("reset state", mark);
        mark = errors;
        test_single_beat();
        report_test("single beat strobes", mark);
        mark = errors;
        test_incr_fixed();
        report_test("incr and fixed bursts", mark);
        mark = errors;
        test_wrap();
        report_test("wrap burst", mark);
        mark = errors;
        test_illegal_wrap();
        report_test("illegal wrap length", mark);
        mark = errors;
        test_concurrent();
        report_test("read stall with write", mark);

        $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/axi_mem_pkg.sv
verilog/sync_fifo.sv
verilog/burst_addr_gen.sv
verilog/axi_write_engine.sv
verilog/axi_read_engine.sv
verilog/mem_arbiter.sv
verilog/axi_mem_slave.sv
verif/axi_mem_slave_tb.sv

//--- Makefile
# Verilator flow for the AXI4 memory slave.

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= axi_mem_slave_tb
RTL_TOP   ?= axi_mem_slave
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/10ps
JOBS      ?= 0
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --Mdir $(OBJ_DIR) \
		--top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
